// File: Makefile
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: sim.f
+incdir+src
src/isaPkg.sv
src/ctrlPkg.sv
src/rTypeDecoder.sv
src/immDecoder.sv
src/controlUnit.sv
tests/controlUnitTb.sv

// File: src/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "isa_consts.svh"

module controlUnit (
    input  logic             clk,
    input  logic             rst,
    input  isaPkg::instrWord instr,
    output ctrlPkg::ctrlWord ctrl
);
    import ctrlPkg::*;

    ctrlWord rCtrl;
    ctrlWord iCtrl;
    ctrlWord nextCtrl;
    logic    isRType;

    rTypeDecoder rTypeDecoder_i (
        .funct (instr.rView.funct),
        .rCtrl (rCtrl)
    );

    immDecoder immDecoder_i (
        .op    (instr.iView.op),
        .iCtrl (iCtrl)
    );

    assign isRType  = (instr.rView.op == `OP_RTYPE);
    assign nextCtrl = isRType ? rCtrl : iCtrl;

    // decode-stage output latch
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl <= '0; // same as a bubble
        end
        else
        begin
            ctrl <= nextCtrl;
        end
    end

endmodule

`default_nettype wire

// File: src/ctrlPkg.sv
`default_nettype none

`include "isa_consts.svh"

package ctrlPkg;

    typedef enum logic [`ALU_W-1:0] {
        aluAdd  = `ALU_ADD,
        aluAddu = `ALU_ADDU,
        aluSub  = `ALU_SUB,
        aluSubu = `ALU_SUBU,
        aluAnd  = `ALU_AND,
        aluOr   = `ALU_OR,
        aluXor  = `ALU_XOR,
        aluSll  = `ALU_SLL,
        aluSrl  = `ALU_SRL,
        aluSra  = `ALU_SRA,
        aluSlt  = `ALU_SLT,
        aluSltu = `ALU_SLTU,
        aluNor  = `ALU_NOR,
        aluSllv = `ALU_SLLV,
        aluSrlv = `ALU_SRLV,
        aluSrav = `ALU_SRAV,
        aluLui  = `ALU_LUI,
        aluPass = `ALU_PASS  // zero-compare branches, register jumps
    } aluOp;

    typedef enum logic [`EXT_W-1:0] {
        extZero  = `EXT_ZERO,
        extSign  = `EXT_SIGN,
        extUpper = `EXT_UPPER
    } extMode;

    typedef struct packed {
        logic branch;
        logic jump;
        logic regDst;
        logic aluSrc;
        logic memToReg;
        logic regWr;
        logic memWr;
        logic rType;
        logic jal;
        logic rTypeJump; // jr / jalr
        logic rTypeLink; // jalr only
    } ctrlFlags;

    typedef struct packed {
        ctrlFlags flags;
        aluOp     aluCtr;
        extMode   ext;
    } ctrlWord;

endpackage

`default_nettype wire

// File: src/immDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "isa_consts.svh"

module immDecoder (
    input  logic [`OPCODE_W-1:0] op,
    output ctrlPkg::ctrlWord     iCtrl
);
    import ctrlPkg::*;

    always_comb
    begin
        iCtrl = '0;

        case (op)
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI:
            begin
                iCtrl.flags.aluSrc = 1'b1; // immediate operand
                iCtrl.flags.regWr  = 1'b1; // result to rt
                case (op)
                    `OP_ADDI:
                    begin
                        iCtrl.aluCtr = aluAdd;
                        iCtrl.ext    = extSign;
                    end
                    `OP_ADDIU:
                    begin
                        iCtrl.aluCtr = aluAddu;
                        iCtrl.ext    = extSign;
                    end
                    `OP_SLTI:
                    begin
                        iCtrl.aluCtr = aluSlt;
                        iCtrl.ext    = extSign;
                    end
                    `OP_SLTIU:
                    begin
                        iCtrl.aluCtr = aluSltu; // still sign extended
                        iCtrl.ext    = extSign;
                    end
                    `OP_ANDI:
                    begin
                        iCtrl.aluCtr = aluAnd;
                        iCtrl.ext    = extZero;
                    end
                    `OP_ORI:
                    begin
                        iCtrl.aluCtr = aluOr;
                        iCtrl.ext    = extZero;
                    end
                    `OP_XORI:
                    begin
                        iCtrl.aluCtr = aluXor;
                        iCtrl.ext    = extZero;
                    end
                    default:
                    begin
                        iCtrl.aluCtr = aluLui; // only lui is left
                        iCtrl.ext    = extUpper;
                    end
                endcase
            end

            `OP_BEQ, `OP_BNE, `OP_REGIMM, `OP_BLEZ, `OP_BGTZ:
            begin
                iCtrl.flags.branch = 1'b1;
                // two-register compares subtract, the rest test rs against zero
                if (op == `OP_BEQ || op == `OP_BNE)
                    iCtrl.aluCtr = aluSub;
                else
                    iCtrl.aluCtr = aluPass;
            end

            `OP_LW, `OP_SW:
            begin
                iCtrl.flags.aluSrc = 1'b1;
                iCtrl.aluCtr       = aluAddu; // base + offset
                iCtrl.ext          = extSign;
                if (op == `OP_LW)
                begin
                    iCtrl.flags.memToReg = 1'b1;
                    iCtrl.flags.regWr    = 1'b1;
                end
                else
                begin
                    iCtrl.flags.memWr = 1'b1;
                end
            end

            `OP_J, `OP_JAL:
            begin
                iCtrl.flags.jump = 1'b1;
                if (op == `OP_JAL)
                begin
                    iCtrl.flags.regWr = 1'b1; // link into r31
                    iCtrl.flags.jal   = 1'b1;
                end
            end

            default:
            begin
                iCtrl = '0; // includes the register-format opcode
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/isaPkg.sv
`default_nettype none

`include "isa_consts.svh"

package isaPkg;

    // register format view
    typedef struct packed {
        logic [`OPCODE_W-1:0] op;
        logic [`REG_W-1:0]    rs;
        logic [`REG_W-1:0]    rt;
        logic [`REG_W-1:0]    rd;
        logic [`SHAMT_W-1:0]  shamt;
        logic [`FUNCT_W-1:0]  funct;
    } rFields;

    // immediate format view
    typedef struct packed {
        logic [`OPCODE_W-1:0] op;
        logic [`REG_W-1:0]    rs;
        logic [`REG_W-1:0]    rt;
        logic [`IMM_W-1:0]    imm;
    } iFields;

    // one fetched word, read either way
    typedef union packed {
        rFields rView;
        iFields iView;
    } instrWord;

endpackage

`default_nettype wire

// File: src/isa_consts.svh
`ifndef ISA_CONSTS_SVH
`define ISA_CONSTS_SVH

// field widths
`define INSTR_W   32
`define OPCODE_W  6
`define FUNCT_W   6
`define REG_W     5
`define SHAMT_W   5
`define IMM_W     16
`define ALU_W     5
`define EXT_W     2

// primary opcodes
`define OP_RTYPE  6'b000000
`define OP_REGIMM 6'b000001 // bgez / bltz, told apart by rt
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_BLEZ   6'b000110
`define OP_BGTZ   6'b000111
`define OP_ADDI   6'b001000
`define OP_ADDIU  6'b001001
`define OP_SLTI   6'b001010
`define OP_SLTIU  6'b001011
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_XORI   6'b001110
`define OP_LUI    6'b001111
`define OP_LW     6'b100011
`define OP_SW     6'b101011

// function field under OP_RTYPE
`define FN_SLL    6'b000000
`define FN_SRL    6'b000010
`define FN_SRA    6'b000011
`define FN_SLLV   6'b000100
`define FN_SRLV   6'b000110
`define FN_SRAV   6'b000111
`define FN_JR     6'b001000
`define FN_JALR   6'b001001
`define FN_ADD    6'b100000
`define FN_ADDU   6'b100001
`define FN_SUB    6'b100010
`define FN_SUBU   6'b100011
`define FN_AND    6'b100100
`define FN_OR     6'b100101
`define FN_XOR    6'b100110
`define FN_NOR    6'b100111
`define FN_SLT    6'b101010
`define FN_SLTU   6'b101011

// ALU operation codes as the datapath ALU expects them
`define ALU_ADD   5'b00000
`define ALU_ADDU  5'b00001
`define ALU_SUB   5'b00010
`define ALU_SUBU  5'b00011
`define ALU_AND   5'b00100
`define ALU_OR    5'b00101
`define ALU_XOR   5'b00110
`define ALU_SLL   5'b01000
`define ALU_SRL   5'b01001
`define ALU_SRA   5'b01011
`define ALU_SLT   5'b01100
`define ALU_SLTU  5'b01101
`define ALU_NOR   5'b01110
`define ALU_SLLV  5'b01111
`define ALU_SRLV  5'b10000
`define ALU_SRAV  5'b10010
`define ALU_LUI   5'b11110
`define ALU_PASS  5'b11111

// immediate extension
`define EXT_ZERO  2'd0
`define EXT_SIGN  2'd1
`define EXT_UPPER 2'd2

`endif

// File: src/rTypeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "isa_consts.svh"

module rTypeDecoder (
    input  logic [`FUNCT_W-1:0] funct,
    output ctrlPkg::ctrlWord    rCtrl
);
    import ctrlPkg::*;

    always_comb
    begin
        rCtrl = '0;
        rCtrl.flags.regDst = 1'b1; // common to all register ops
        rCtrl.flags.regWr  = 1'b1;
        rCtrl.flags.rType  = 1'b1;

        case (funct)
            `FN_ADD:  rCtrl.aluCtr = aluAdd;
            `FN_ADDU: rCtrl.aluCtr = aluAddu;
            `FN_SUB:  rCtrl.aluCtr = aluSub;
            `FN_SUBU: rCtrl.aluCtr = aluSubu;
            `FN_AND:  rCtrl.aluCtr = aluAnd;
            `FN_OR:   rCtrl.aluCtr = aluOr;
            `FN_NOR:  rCtrl.aluCtr = aluNor;
            `FN_XOR:  rCtrl.aluCtr = aluXor;
            `FN_SLT:  rCtrl.aluCtr = aluSlt;
            `FN_SLTU: rCtrl.aluCtr = aluSltu;
            `FN_SLL:  rCtrl.aluCtr = aluSll;  // shamt shifts
            `FN_SRL:  rCtrl.aluCtr = aluSrl;
            `FN_SRA:  rCtrl.aluCtr = aluSra;
            `FN_SLLV: rCtrl.aluCtr = aluSllv; // rs shifts
            `FN_SRLV: rCtrl.aluCtr = aluSrlv;
            `FN_SRAV: rCtrl.aluCtr = aluSrav;
            `FN_JALR:
            begin
                rCtrl.aluCtr          = aluPass;
                rCtrl.flags.rTypeJump = 1'b1;
                rCtrl.flags.rTypeLink = 1'b1; // return address to rd
            end
            `FN_JR:
            begin
                rCtrl.aluCtr          = aluPass;
                rCtrl.flags.rTypeJump = 1'b1;
                rCtrl.flags.regWr     = 1'b0; // no link
            end
            default:
            begin
                rCtrl = '0; // unknown funct acts as a bubble
            end
        endcase
    end

endmodule

`default_nettype wire

// File: tests/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "isa_consts.svh"

module controlUnitTb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int MAX_TESTS = 64;
    localparam int FIELDS    = 5; // op, funct, flags, alu, ext

    logic             clk;
    logic             rst;
    instrWord         instr;
    ctrlWord          ctrl;

    logic [15:0]      stimMem [0:MAX_TESTS*FIELDS-1];
    int               numTests;
    logic             stimLoaded;
    integer           seed;
    ctrlWord          expQ [$];

    controlUnit controlUnit_i (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .ctrl  (ctrl)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic endWithFailure();
        $display("sim failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic checkFlags(input ctrlFlags expV, input ctrlFlags actV, input int idx);
        if (actV !== expV)
        begin
            $display("[ERROR] %0t ns: test %0d flags expected %b, got %b",
                     $time, idx, expV, actV);
            endWithFailure();
        end
    endtask

    task automatic checkAluOp(input aluOp expV, input aluOp actV, input int idx);
        if (actV !== expV)
        begin
            $display("[ERROR] %0t ns: test %0d aluCtr expected %h, got %h",
                     $time, idx, expV, actV);
            endWithFailure();
        end
    endtask

    task automatic checkExt(input extMode expV, input extMode actV, input int idx);
        if (actV !== expV)
        begin
            $display("[ERROR] %0t ns: test %0d ext expected %h, got %h",
                     $time, idx, expV, actV);
            endWithFailure();
        end
    endtask

    // op and funct from the file and every other field random
    task automatic buildInstr(input int idx, output instrWord w);
        logic [`INSTR_W-1:0] rnd;
        rnd = $random(seed);
        w = rnd;
        w.rView.op = stimMem[idx*FIELDS][5:0];
        if (w.rView.op == `OP_RTYPE)
            w.rView.funct = stimMem[idx*FIELDS+1][5:0];
    endtask

    function automatic ctrlWord expectedCtrl(input int idx);
        int      base;
        ctrlWord c;
        base     = idx * FIELDS;
        c.flags  = ctrlFlags'(stimMem[base+2][10:0]);
        c.aluCtr = aluOp'(stimMem[base+3][4:0]);
        c.ext    = extMode'(stimMem[base+4][1:0]);
        return c;
    endfunction

    // limit scales with the number of file entries
    initial
    begin
        wait (stimLoaded);
        #((numTests + 8 + 20) * 8);
        $display("watchdog expired before the test sequence finished");
        $display("sim failed");
        $fatal(1, "timeout");
    end

    initial
    begin
        ctrlWord expV;
        instrWord nextInstr;
        rst        = 1'b1;
        instr      = '0;
        seed       = 96;
        numTests   = 0;
        stimLoaded = 1'b0;

        for (int i = 0; i < MAX_TESTS*FIELDS; i++)
            stimMem[i] = 16'h8000 | 16'(i); // bit 15 marks unused slots
        $readmemh("tests/decode_stimulus.txt", stimMem);
        while (numTests < MAX_TESTS && stimMem[numTests*FIELDS][15] == 1'b0)
            numTests++;
        if (numTests == 0)
        begin
            $display("stimulus file tests/decode_stimulus.txt is missing or holds no tests");
            endWithFailure();
        end
        stimLoaded = 1'b1;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk); // still the reset value
        checkFlags(ctrlFlags'('0), ctrl.flags, -1);
        checkAluOp(aluAdd, ctrl.aluCtr, -1);
        checkExt(extZero, ctrl.ext, -1);

        for (int k = 0; k <= numTests; k++)
        begin
            @(posedge clk);
            if (k < numTests)
            begin
                buildInstr(k, nextInstr);
                instr <= nextInstr;
                expQ.push_back(expectedCtrl(k));
            end
            @(negedge clk);
            if (k > 0)
            begin
                expV = expQ.pop_front(); // word of the previous cycle
                checkFlags(expV.flags, ctrl.flags, k - 1);
                checkAluOp(expV.aluCtr, ctrl.aluCtr, k - 1);
                checkExt(expV.ext, ctrl.ext, k - 1);
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/decode_stimulus.txt
// columns, all hex: opcode funct flags(11 bit) aluCtr ext
// flags bit order: branch jump regDst aluSrc memToReg regWr memWr rType jal rTypeJump rTypeLink
00 20 128 00 0 // add
00 21 128 01 0 // addu
00 22 128 02 0 // sub
00 23 128 03 0 // subu
00 24 128 04 0 // and
00 25 128 05 0 // or
00 27 128 0e 0 // nor
00 26 128 06 0 // xor
00 2a 128 0c 0 // slt
00 2b 128 0d 0 // sltu
00 00 128 08 0 // sll
00 02 128 09 0 // srl
00 03 128 0b 0 // sra
00 04 128 0f 0 // sllv
00 06 128 10 0 // srlv
00 07 128 12 0 // srav
00 09 12b 1f 0 // jalr
00 08 10a 1f 0 // jr
08 00 0a0 00 1 // addi
09 00 0a0 01 1 // addiu
0a 00 0a0 0c 1 // slti
0b 00 0a0 0d 1 // sltiu
0c 00 0a0 04 0 // andi
0d 00 0a0 05 0 // ori
0e 00 0a0 06 0 // xori
0f 00 0a0 1e 2 // lui
04 00 400 02 0 // beq
05 00 400 02 0 // bne
01 00 400 1f 0 // bgez / bltz
06 00 400 1f 0 // blez
07 00 400 1f 0 // bgtz
23 00 0e0 01 1 // lw
2b 00 090 01 1 // sw
02 00 200 00 0 // j
03 00 224 00 0 // jal
20 00 000 00 0 // lb, dropped
24 00 000 00 0 // lbu, dropped
28 00 000 00 0 // sb, dropped
3f 00 000 00 0 // unused opcode
00 01 000 00 0 // unknown funct
00 3f 000 00 0 // unknown funct
